/* design/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data and address width
`define RV_XLEN 32

// register file size and index width
`define RV_NREGS 32
`define RV_RADDR_W 5

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* design/rv_pkg.sv */
package rv_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // branch offset bits are scattered, bit 0 is implied
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef enum logic [5:0] {
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LW, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_EBREAK, OP_ILLEGAL
    } op_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_fn_e;

endpackage

/* design/rv_ifs.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

// decoded instruction, idu to exu
interface dec_if import rv_pkg::*; ();
    op_e                    op;
    logic [`RV_RADDR_W-1:0] rd;
    logic [`RV_RADDR_W-1:0] rs1;
    logic [`RV_RADDR_W-1:0] rs2;
    // shift amount rides in imm[4:0]
    logic [`RV_XLEN-1:0]    imm;

    modport dec (output op, rd, rs1, rs2, imm);
    modport exe (input op, rd, rs1, rs2, imm);
endinterface

interface alu_if import rv_pkg::*; ();
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    alu_fn_e             fn;
    logic [`RV_XLEN-1:0] result;

    modport ctl (output a, b, fn, input result);
    modport unit (input a, b, fn, output result);
endinterface

/* design/rv_ifu.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_ifu (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`RV_XLEN-1:0] next_pc,
    input  logic                pc_en,
    output logic [`RV_XLEN-1:0] pc
);

    // pc doubles as the fetch address, imem answers in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RV_RESET_PC;
        end else if (pc_en) begin
            pc <= next_pc;
        end
    end

    // no misalignment trap, so every target from exu must stay word aligned
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00
    );

endmodule

/* design/rv_idu.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_idu import rv_pkg::*; (
    input  logic [`RV_XLEN-1:0]    inst,
    output logic [`RV_RADDR_W-1:0] rs1,
    output logic [`RV_RADDR_W-1:0] rs2,
    dec_if.dec                     dec
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    inst_u               w;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    assign w = inst;

    assign imm_i = {{20{w.i.imm[11]}}, w.i.imm};
    assign imm_s = {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
    assign imm_b = {{19{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
    assign imm_u = {w.u.imm, 12'b0};
    assign imm_j = {{11{w.j.imm20}}, w.j.imm20, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};

    // source fields sit at the same bits in every format
    assign rs1     = w.r.rs1;
    assign rs2     = w.r.rs2;
    assign dec.rs1 = w.r.rs1;
    assign dec.rs2 = w.r.rs2;

    always_comb begin
        dec.op  = OP_ILLEGAL;
        dec.rd  = w.r.rd;
        dec.imm = imm_i;
        case (w.r.opcode)
            OPC_LUI: begin
                dec.op  = OP_LUI;
                dec.imm = imm_u;
            end
            OPC_AUIPC: begin
                dec.op  = OP_AUIPC;
                dec.imm = imm_u;
            end
            OPC_JAL: begin
                dec.op  = OP_JAL;
                dec.imm = imm_j;
            end
            OPC_JALR: begin
                if (w.i.funct3 == 3'b000) dec.op = OP_JALR;
            end
            OPC_BRANCH: begin
                dec.rd  = '0;
                dec.imm = imm_b;
                case (w.b.funct3)
                    3'b000:  dec.op = OP_BEQ;
                    3'b001:  dec.op = OP_BNE;
                    3'b100:  dec.op = OP_BLT;
                    3'b101:  dec.op = OP_BGE;
                    3'b110:  dec.op = OP_BLTU;
                    3'b111:  dec.op = OP_BGEU;
                    default: dec.op = OP_ILLEGAL;
                endcase
            end
            OPC_LOAD: begin
                if (w.i.funct3 == 3'b010) dec.op = OP_LW;
            end
            OPC_STORE: begin
                dec.rd  = '0;
                dec.imm = imm_s;
                if (w.s.funct3 == 3'b010) dec.op = OP_SW;
            end
            OPC_OPIMM: begin
                case (w.i.funct3)
                    3'b000: dec.op = OP_ADDI;
                    3'b010: dec.op = OP_SLTI;
                    3'b011: dec.op = OP_SLTIU;
                    3'b100: dec.op = OP_XORI;
                    3'b110: dec.op = OP_ORI;
                    3'b111: dec.op = OP_ANDI;
                    3'b001: begin
                        if (w.r.funct7 == 7'b0000000) dec.op = OP_SLLI;
                    end
                    default: begin
                        if (w.r.funct7 == 7'b0000000) dec.op = OP_SRLI;
                        else if (w.r.funct7 == 7'b0100000) dec.op = OP_SRAI;
                    end
                endcase
            end
            OPC_OP: begin
                case ({w.r.funct7, w.r.funct3})
                    10'b0000000_000: dec.op = OP_ADD;
                    10'b0100000_000: dec.op = OP_SUB;
                    10'b0000000_001: dec.op = OP_SLL;
                    10'b0000000_010: dec.op = OP_SLT;
                    10'b0000000_011: dec.op = OP_SLTU;
                    10'b0000000_100: dec.op = OP_XOR;
                    10'b0000000_101: dec.op = OP_SRL;
                    10'b0100000_101: dec.op = OP_SRA;
                    10'b0000000_110: dec.op = OP_OR;
                    10'b0000000_111: dec.op = OP_AND;
                    default:         dec.op = OP_ILLEGAL;
                endcase
            end
            OPC_SYSTEM: begin
                // only the exact ebreak word, ecall and csr ops are illegal here
                dec.rd = '0;
                if (inst == 32'h0010_0073) dec.op = OP_EBREAK;
            end
            default: dec.op = OP_ILLEGAL;
        endcase
    end

endmodule

/* design/rv_gpr.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_gpr (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`RV_RADDR_W-1:0] rs1,
    input  logic [`RV_RADDR_W-1:0] rs2,
    output logic [`RV_XLEN-1:0]    rs1_val,
    output logic [`RV_XLEN-1:0]    rs2_val,
    output logic [`RV_XLEN-1:0]    a0_val,
    input  logic                   wr_en,
    input  logic [`RV_RADDR_W-1:0] wr_addr,
    input  logic [`RV_XLEN-1:0]    wr_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    // x0 is never written, so it keeps its reset zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_val = regs[rs1];
    assign rs2_val = regs[rs2];
    // a0 is x10, the exit code on ebreak
    assign a0_val  = regs[10];

endmodule

/* design/rv_alu.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_alu import rv_pkg::*; (
    alu_if.unit alu
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = alu.b[4:0];
    assign lt_s  = $signed(alu.a) < $signed(alu.b);
    assign lt_u  = alu.a < alu.b;

    always_comb begin
        case (alu.fn)
            ALU_ADD:  alu.result = alu.a + alu.b;
            ALU_SUB:  alu.result = alu.a - alu.b;
            ALU_SLL:  alu.result = alu.a << shamt;
            ALU_SLT:  alu.result = {{(`RV_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: alu.result = {{(`RV_XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  alu.result = alu.a ^ alu.b;
            ALU_SRL:  alu.result = alu.a >> shamt;
            ALU_SRA:  alu.result = $signed(alu.a) >>> shamt;
            ALU_OR:   alu.result = alu.a | alu.b;
            ALU_AND:  alu.result = alu.a & alu.b;
            // pass_b, used by lui
            default:  alu.result = alu.b;
        endcase
    end

endmodule

/* design/rv_exu.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_exu import rv_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    dec_if.exe                     dec,
    input  logic [`RV_XLEN-1:0]    pc,
    input  logic [`RV_XLEN-1:0]    rs1_val,
    input  logic [`RV_XLEN-1:0]    rs2_val,
    input  logic [`RV_XLEN-1:0]    a0_val,
    alu_if.ctl                     alu,
    output logic                   wr_en,
    output logic [`RV_RADDR_W-1:0] wr_addr,
    output logic [`RV_XLEN-1:0]    wr_data,
    output logic [`RV_XLEN-1:0]    next_pc,
    output logic                   pc_en,
    output logic [`RV_XLEN-1:0]    dmem_addr,
    output logic [`RV_XLEN-1:0]    dmem_wdata,
    output logic                   dmem_we,
    input  logic [`RV_XLEN-1:0]    dmem_rdata,
    output logic                   halt,
    output logic                   illegal,
    output logic [`RV_XLEN-1:0]    halt_pc,
    output logic [`RV_XLEN-1:0]    exit_code
);

    logic [`RV_XLEN-1:0] pc_plus4;
    logic                take;
    logic                is_jump;
    logic                writes;
    logic                stop;

    assign pc_plus4 = pc + 4;
    assign is_jump  = dec.op inside {OP_JAL, OP_JALR};
    assign stop     = dec.op inside {OP_EBREAK, OP_ILLEGAL};
    assign writes   = !(dec.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
                                       OP_SW, OP_EBREAK, OP_ILLEGAL});

    // operand a is rs1 except for auipc, b is imm except for reg-reg ops
    always_comb begin
        alu.a = (dec.op == OP_AUIPC) ? pc : rs1_val;
        alu.b = (dec.op inside {[OP_ADD:OP_AND]}) ? rs2_val : dec.imm;
        case (dec.op)
            OP_SUB:           alu.fn = ALU_SUB;
            OP_SLL, OP_SLLI:  alu.fn = ALU_SLL;
            OP_SLT, OP_SLTI:  alu.fn = ALU_SLT;
            OP_SLTU, OP_SLTIU: alu.fn = ALU_SLTU;
            OP_XOR, OP_XORI:  alu.fn = ALU_XOR;
            OP_SRL, OP_SRLI:  alu.fn = ALU_SRL;
            OP_SRA, OP_SRAI:  alu.fn = ALU_SRA;
            OP_OR, OP_ORI:    alu.fn = ALU_OR;
            OP_AND, OP_ANDI:  alu.fn = ALU_AND;
            OP_LUI:           alu.fn = ALU_PASS_B;
            // add also forms load/store addresses and the jalr target
            default:          alu.fn = ALU_ADD;
        endcase
    end

    always_comb begin
        case (dec.op)
            OP_BEQ:  take = rs1_val == rs2_val;
            OP_BNE:  take = rs1_val != rs2_val;
            OP_BLT:  take = $signed(rs1_val) < $signed(rs2_val);
            OP_BGE:  take = $signed(rs1_val) >= $signed(rs2_val);
            OP_BLTU: take = rs1_val < rs2_val;
            OP_BGEU: take = rs1_val >= rs2_val;
            OP_JAL:  take = 1'b1;
            default: take = 1'b0;
        endcase
    end

    always_comb begin
        if (dec.op == OP_JALR) begin
            next_pc = {alu.result[`RV_XLEN-1:1], 1'b0};
        end else if (take) begin
            next_pc = pc + dec.imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_comb begin
        if (is_jump) begin
            wr_data = pc_plus4;
        end else if (dec.op == OP_LW) begin
            wr_data = dmem_rdata;
        end else begin
            wr_data = alu.result;
        end
    end

    assign wr_en      = !halt && writes && dec.rd != '0;
    assign wr_addr    = dec.rd;
    assign dmem_addr  = alu.result;
    assign dmem_wdata = rs2_val;
    assign dmem_we    = !halt && dec.op == OP_SW;
    // pc stays on the ebreak or illegal word
    assign pc_en      = !halt && !stop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halt      <= 1'b0;
            illegal   <= 1'b0;
            halt_pc   <= '0;
            exit_code <= '0;
        end else if (!halt && stop) begin
            halt      <= 1'b1;
            illegal   <= dec.op == OP_ILLEGAL;
            halt_pc   <= pc;
            exit_code <= a0_val;
        end
    end

    a_quiet_halted: assert property (
        @(posedge clk) disable iff (!rst_n)
        halt |-> !(dmem_we || wr_en || pc_en)
    );

    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> wr_addr != '0
    );

endmodule

/* design/rv_core.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core (
    input  logic                clk,
    input  logic                rst_n,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0] imem_rdata,
    output logic [`RV_XLEN-1:0] dmem_addr,
    output logic [`RV_XLEN-1:0] dmem_wdata,
    output logic                dmem_we,
    input  logic [`RV_XLEN-1:0] dmem_rdata,
    output logic                halt,
    output logic                illegal,
    output logic [`RV_XLEN-1:0] halt_pc,
    output logic [`RV_XLEN-1:0] exit_code
);

    logic [`RV_XLEN-1:0]    pc;
    logic [`RV_XLEN-1:0]    next_pc;
    logic                   pc_en;
    logic [`RV_RADDR_W-1:0] rs1;
    logic [`RV_RADDR_W-1:0] rs2;
    logic [`RV_XLEN-1:0]    rs1_val;
    logic [`RV_XLEN-1:0]    rs2_val;
    logic [`RV_XLEN-1:0]    a0_val;
    logic                   wr_en;
    logic [`RV_RADDR_W-1:0] wr_addr;
    logic [`RV_XLEN-1:0]    wr_data;

    dec_if dec_bus ();
    alu_if alu_bus ();

    assign imem_addr = pc;

    rv_ifu ifu0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .next_pc (next_pc),
        .pc_en   (pc_en),
        .pc      (pc)
    );

    rv_idu idu0 (
        .inst (imem_rdata),
        .rs1  (rs1),
        .rs2  (rs2),
        .dec  (dec_bus.dec)
    );

    rv_gpr gpr0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .a0_val  (a0_val),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    rv_alu alu0 (
        .alu (alu_bus.unit)
    );

    rv_exu exu0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec        (dec_bus.exe),
        .pc         (pc),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .a0_val     (a0_val),
        .alu        (alu_bus.ctl),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .next_pc    (next_pc),
        .pc_en      (pc_en),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .halt       (halt),
        .illegal    (illegal),
        .halt_pc    (halt_pc),
        .exit_code  (exit_code)
    );

endmodule

/* dv/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

    localparam int MEM_WORDS = 256;
    localparam int MAX_EXP   = 64;
    localparam int TIMEOUT   = 2000;
    // byte address of the first result slot, above the program
    localparam int DATA_BASE = 832;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;
    logic        halt;
    logic        illegal;
    logic [31:0] halt_pc;
    logic [31:0] exit_code;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] prog [MEM_WORDS];
    int          pw;
    logic [31:0] rng_state;
    logic [31:0] last_addr;

    logic [31:0] exp_addr [MAX_EXP];
    logic [31:0] exp_data [MAX_EXP];
    string       exp_name [MAX_EXP];
    int          exp_count;
    int          chk_idx;
    logic [5:0]  cur;
    logic [31:0] exp_halt_pc;
    logic [31:0] exp_exit;
    logic        exp_illegal;

    rv_core dut0 (.*);

    always #50 clk = ~clk;

    // shared memory, reloaded from prog while reset is low
    assign imem_rdata = mem[imem_addr[9:2]];
    assign dmem_rdata = mem[dmem_addr[9:2]];
    assign cur        = chk_idx[5:0];

    always @(posedge clk) begin
        if (!rst_n) begin
            mem     <= prog;
            chk_idx <= 0;
        end else if (dmem_we) begin
            mem[dmem_addr[9:2]] <= dmem_wdata;
            chk_idx             <= chk_idx + 1;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] expv, input logic [31:0] actv);
        abort_run($sformatf("FAILED %s expected %h actual %h", name, expv, actv));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(output logic [31:0] v);
        rng_state = xorshift32(rng_state);
        v = rng_state;
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // expected alu result, funct3 plus the funct7 alternate bit
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic clear_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i[7:0]] = {24'hbad_c0d, i[7:0]};
        end
        pw = 0;
    endtask

    task automatic emit(input logic [31:0] w);
        prog[pw[7:0]] = w;
        pw++;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = v + 32'h800;
        emit(u_type(upper[31:12], rd, 7'b0110111));
        emit(i_type(v[11:0], rd, 3'b000, rd, 7'b0010011));
    endtask

    // store rs to the next result slot and queue the expected pair
    task automatic store_check(input logic [4:0] rs, input string name, input logic [31:0] v);
        logic [31:0] addr;
        addr = DATA_BASE + 4 * exp_count;
        emit(s_type(addr[11:0], rs, 5'd0));
        exp_addr[exp_count[5:0]] = addr;
        exp_data[exp_count[5:0]] = v;
        exp_name[exp_count[5:0]] = name;
        exp_count++;
        last_addr = addr;
    endtask

    task automatic alu_rr_test(input logic [2:0] f3, input logic alt, input string name);
        logic [31:0] a;
        logic [31:0] b;
        draw(a);
        draw(b);
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(r_type({1'b0, alt, 5'b0}, 5'd2, 5'd1, f3, 5'd3));
        store_check(5'd3, name, alu_ref(f3, alt, a, b));
    endtask

    task automatic alu_ri_test(input logic [2:0] f3, input logic alt, input string name);
        logic [31:0] a;
        logic [31:0] r;
        logic [11:0] imm;
        draw(a);
        draw(r);
        if (f3 == 3'b001 || f3 == 3'b101) imm = {1'b0, alt, 5'b0, r[4:0]};
        else imm = r[11:0];
        load_const(5'd1, a);
        emit(i_type(imm, 5'd1, f3, 5'd4, 7'b0010011));
        store_check(5'd4, name, alu_ref(f3, alt, a, {{20{imm[11]}}, imm}));
    endtask

    // x5 gets the taken marker, overwritten on the fall-through path
    task automatic branch_case(input logic [2:0] f3, input logic [4:0] ra, input logic [4:0] rb,
                               input logic [31:0] va, input logic [31:0] vb, input string name);
        logic [11:0] mark_t;
        logic [11:0] mark_nt;
        mark_t  = 12'h400 | 12'(exp_count);
        mark_nt = 12'h200 | 12'(exp_count);
        emit(i_type(mark_t, 5'd0, 3'b000, 5'd5, 7'b0010011));
        emit(b_type(13'd8, rb, ra, f3));
        emit(i_type(mark_nt, 5'd0, 3'b000, 5'd5, 7'b0010011));
        store_check(5'd5, name, branch_ref(f3, va, vb) ? {20'h0, mark_t} : {20'h0, mark_nt});
    endtask

    // a != b, so swapped or same operands give the opposite outcome
    task automatic branch_test(input logic [2:0] f3, input string name);
        logic [31:0] a;
        logic [31:0] b;
        draw(a);
        draw(b);
        if (a == b) b = a ^ 32'h1;
        load_const(5'd1, a);
        load_const(5'd2, b);
        branch_case(f3, 5'd1, 5'd2, a, b, {name, " first"});
        if (f3[2]) branch_case(f3, 5'd2, 5'd1, b, a, {name, " swapped"});
        else branch_case(f3, 5'd1, 5'd1, a, a, {name, " same"});
    endtask

    task automatic jump_tests();
        logic [31:0] base;
        logic [31:0] r;
        base = pw * 4;
        emit(u_type(20'h0, 5'd8, 7'b0010111));
        // odd offset, target lands on base + 12
        emit(i_type(12'd13, 5'd8, 3'b000, 5'd9, 7'b1100111));
        emit(32'h0);
        store_check(5'd8, "auipc zero", base);
        store_check(5'd9, "jalr link", base + 8);
        base = pw * 4;
        emit(j_type(21'd8, 5'd6));
        emit(32'h0);
        store_check(5'd6, "jal link", base + 4);
        draw(r);
        emit(u_type(r[31:12], 5'd12, 7'b0110111));
        store_check(5'd12, "lui", {r[31:12], 12'h0});
        base = pw * 4;
        emit(u_type(r[19:0], 5'd11, 7'b0010111));
        store_check(5'd11, "auipc offset", base + {r[19:0], 12'h0});
    endtask

    task automatic build_main_program();
        logic [31:0] r;
        clear_program();
        alu_rr_test(3'b000, 1'b0, "add");
        alu_rr_test(3'b000, 1'b1, "sub");
        alu_rr_test(3'b001, 1'b0, "sll");
        alu_rr_test(3'b010, 1'b0, "slt");
        alu_rr_test(3'b011, 1'b0, "sltu");
        alu_rr_test(3'b100, 1'b0, "xor");
        alu_rr_test(3'b101, 1'b0, "srl");
        alu_rr_test(3'b101, 1'b1, "sra");
        alu_rr_test(3'b110, 1'b0, "or");
        alu_rr_test(3'b111, 1'b0, "and");
        alu_ri_test(3'b000, 1'b0, "addi");
        alu_ri_test(3'b010, 1'b0, "slti");
        alu_ri_test(3'b011, 1'b0, "sltiu");
        alu_ri_test(3'b100, 1'b0, "xori");
        alu_ri_test(3'b110, 1'b0, "ori");
        alu_ri_test(3'b111, 1'b0, "andi");
        alu_ri_test(3'b001, 1'b0, "slli");
        alu_ri_test(3'b101, 1'b0, "srli");
        alu_ri_test(3'b101, 1'b1, "srai");
        branch_test(3'b000, "beq");
        branch_test(3'b001, "bne");
        branch_test(3'b100, "blt");
        branch_test(3'b101, "bge");
        branch_test(3'b110, "bltu");
        branch_test(3'b111, "bgeu");
        jump_tests();
        draw(r);
        load_const(5'd13, r);
        store_check(5'd13, "sw", r);
        emit(i_type(last_addr[11:0], 5'd0, 3'b010, 5'd14, 7'b0000011));
        store_check(5'd14, "lw", r);
        emit(i_type(r[11:0], 5'd0, 3'b000, 5'd0, 7'b0010011));
        store_check(5'd0, "x0 after write", 32'h0);
        draw(r);
        load_const(5'd10, r);
        exp_exit    = r;
        exp_halt_pc = pw * 4;
        exp_illegal = 1'b0;
        emit(32'h0010_0073);
        // never reached once halted
        emit(s_type(12'h0, 5'd10, 5'd0));
        if (pw * 4 > DATA_BASE) abort_run("program runs into the result area");
    endtask

    task automatic wait_for_halt(input string what);
        int n;
        n = 0;
        while (!halt && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!halt) abort_run($sformatf("%s did not halt within %0d cycles", what, TIMEOUT));
        repeat (4) @(negedge clk);
    endtask

    a_store_expected: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_we |-> chk_idx < exp_count)
        else abort_run($sformatf("unexpected store to %h", $sampled(dmem_addr)));

    a_store_addr: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_we && chk_idx < exp_count |-> dmem_addr == exp_addr[cur])
        else mismatch({exp_name[$sampled(cur)], " address"}, exp_addr[$sampled(cur)],
                      $sampled(dmem_addr));

    a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_we && chk_idx < exp_count |-> dmem_wdata == exp_data[cur])
        else mismatch(exp_name[$sampled(cur)], exp_data[$sampled(cur)], $sampled(dmem_wdata));

    a_halt_pc: assert property (@(posedge clk) disable iff (!rst_n)
        halt |-> halt_pc == exp_halt_pc)
        else mismatch("halt_pc", exp_halt_pc, $sampled(halt_pc));

    a_exit_code: assert property (@(posedge clk) disable iff (!rst_n)
        halt |-> exit_code == exp_exit)
        else mismatch("exit_code", exp_exit, $sampled(exit_code));

    a_illegal: assert property (@(posedge clk) disable iff (!rst_n)
        halt |-> illegal == exp_illegal)
        else mismatch("illegal", {31'b0, exp_illegal}, {31'b0, $sampled(illegal)});

    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        halt |-> !dmem_we)
        else abort_run("store issued while halted");

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        rng_state   = 32'ha9b5_4172;
        exp_count   = 0;
        build_main_program();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        wait_for_halt("main program");
        if (chk_idx != exp_count) begin
            abort_run($sformatf("main program made %0d of %0d stores", chk_idx, exp_count));
        end

        // fresh reset, ecall as the first word is outside the supported set
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        clear_program();
        emit(32'h0000_0073);
        emit(s_type(12'h0, 5'd10, 5'd0));
        exp_count   = 0;
        exp_halt_pc = 32'h0;
        exp_exit    = 32'h0;
        exp_illegal = 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        wait_for_halt("illegal program");
        if (chk_idx == exp_count) begin
            $display("Everything OK");
            $finish;
        end else begin
            abort_run("illegal program stored to memory");
        end
    end

endmodule

/* files.f */
+incdir+design
design/rv_pkg.sv
design/rv_ifs.sv
design/rv_ifu.sv
design/rv_idu.sv
design/rv_gpr.sv
design/rv_alu.sv
design/rv_exu.sv
design/rv_core.sv
dv/rv_core_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --assert -f files.f --top-module rv_core_tb -o rv_core_sim || exit 1
out=$(./obj_dir/rv_core_sim)
echo "$out"
echo "$out" | grep -q "Everything OK" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
